/* Makefile */
# Verilator build and run for the machine-mode CSR unit

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= TESTS PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
rtl/csr_pkg.sv
rtl/csr_trap_eval.sv
rtl/csr_access.sv
rtl/csr_regfile.sv
rtl/csr_unit.sv
sim/csr_unit_props.sv
sim/csr_unit_tb.sv

/* rtl/csr_access.sv */
// CSR access path
// decodes the CSR address, selects the read value and forms the write request
`timescale 1ns/100ps
`default_nettype none

module csr_access (
    input  csr_pkg::stage_instr_t      s_instr_i,
    input  logic                       s_flush_i,
    input  logic                       s_stall_i,
    input  csr_pkg::csr_state_t        s_state_i,
    output logic [csr_pkg::XLEN-1:0]   s_rdata_o,
    output csr_pkg::csr_wr_t           s_wr_o
);
    import csr_pkg::*;

    logic            csr_op;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] wdata;

    assign csr_op = (s_instr_i.op == OP_CSRRW) | (s_instr_i.op == OP_CSRRS) |
                    (s_instr_i.op == OP_CSRRC);

    always_comb begin : read_mux
        case (s_instr_i.csr_addr)
            MSTATUS:   rdata = MSTATUS_MPP_BITS |
                               {24'b0, s_state_i.mstatus_mpie, 3'b0, s_state_i.mstatus_mie, 3'b0};
            MISA:      rdata = MISA_VAL;
            MIE:       rdata = s_state_i.mie;
            MTVEC:     rdata = s_state_i.mtvec;
            MSCRATCH:  rdata = s_state_i.mscratch;
            MEPC:      rdata = s_state_i.mepc;
            MCAUSE:    rdata = s_state_i.mcause;
            MTVAL:     rdata = s_state_i.mtval;
            MIP:       rdata = s_state_i.mip;
            MCYCLE:    rdata = s_state_i.mcycle;
            MCYCLEH:   rdata = s_state_i.mcycleh;
            MINSTRET:  rdata = s_state_i.minstret;
            MINSTRETH: rdata = s_state_i.minstreth;
            MHARTID:   rdata = '0;           // single hart
            default:   rdata = '0;
        endcase
    end

    // read-modify-write on the value before this instruction
    always_comb begin : modify_value
        case (s_instr_i.op)
            OP_CSRRW: wdata = s_instr_i.val;
            OP_CSRRS: wdata = rdata | s_instr_i.val;
            OP_CSRRC: wdata = rdata & ~s_instr_i.val;
            default:  wdata = rdata;
        endcase
    end

    assign s_rdata_o = rdata;

    assign s_wr_o.we   = csr_op & s_instr_i.valid & ~s_flush_i & ~s_stall_i;
    assign s_wr_o.addr = s_instr_i.csr_addr;
    assign s_wr_o.data = wdata;

endmodule

`default_nettype wire

/* rtl/csr_pkg.sv */
// machine-mode CSR unit definitions
// CSR addresses, cause codes, stage encodings and the structs shared between blocks
`default_nettype none

package csr_pkg;

    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int CAUSE_W    = 5;

    // standard machine CSR addresses
    localparam logic [CSR_ADDR_W-1:0] MSTATUS   = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] MISA      = 12'h301;
    localparam logic [CSR_ADDR_W-1:0] MIE       = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] MTVEC     = 12'h305;
    localparam logic [CSR_ADDR_W-1:0] MSCRATCH  = 12'h340;
    localparam logic [CSR_ADDR_W-1:0] MEPC      = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] MCAUSE    = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] MTVAL     = 12'h343;
    localparam logic [CSR_ADDR_W-1:0] MIP       = 12'h344;
    localparam logic [CSR_ADDR_W-1:0] MCYCLE    = 12'hB00;
    localparam logic [CSR_ADDR_W-1:0] MINSTRET  = 12'hB02;
    localparam logic [CSR_ADDR_W-1:0] MCYCLEH   = 12'hB80;
    localparam logic [CSR_ADDR_W-1:0] MINSTRETH = 12'hB82;
    localparam logic [CSR_ADDR_W-1:0] MHARTID   = 12'hF14;

    localparam logic [XLEN-1:0] MISA_VAL         = 32'h4000_1104; // MXL=1, I, M, C
    localparam logic [XLEN-1:0] MSTATUS_MPP_BITS = 32'h0000_1800; // MPP fixed to M
    localparam logic [XLEN-1:0] MIE_MASK         = 32'h0000_0888; // MEIE, MTIE, MSIE

    // exception causes
    localparam logic [CAUSE_W-1:0] EXC_IACCESS   = 5'd1;
    localparam logic [CAUSE_W-1:0] EXC_ILLEGAL   = 5'd2;
    localparam logic [CAUSE_W-1:0] EXC_EBREAK    = 5'd3;
    localparam logic [CAUSE_W-1:0] EXC_LMISALIGN = 5'd4;
    localparam logic [CAUSE_W-1:0] EXC_SMISALIGN = 5'd6;
    localparam logic [CAUSE_W-1:0] EXC_ECALL_M   = 5'd11;

    // interrupt causes, bit 31 of mcause added on entry
    localparam logic [CAUSE_W-1:0] INT_MSI = 5'd3;
    localparam logic [CAUSE_W-1:0] INT_MTI = 5'd7;
    localparam logic [CAUSE_W-1:0] INT_MEI = 5'd11;

    typedef enum logic [3:0] {
        OP_NONE,
        OP_OTHER,
        OP_CSRRW,
        OP_CSRRS,
        OP_CSRRC,
        OP_ECALL,
        OP_EBREAK,
        OP_MRET,
        OP_LOAD_W,
        OP_LOAD_H,
        OP_LOAD_B,
        OP_STORE_W,
        OP_STORE_H,
        OP_STORE_B
    } instr_op_e;

    typedef enum logic [1:0] {
        MIS_NONE,
        MIS_ILLEGAL,
        MIS_FETCH_ERR
    } imiscon_e;

    typedef struct packed {
        logic                  valid;
        instr_op_e             op;
        imiscon_e              misc;
        logic [CSR_ADDR_W-1:0] csr_addr;
        logic [XLEN-1:0]       val;      // CSR operand or load/store address
        logic [XLEN-1:0]       pc;
    } stage_instr_t;

    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_lines_t;

    typedef struct packed {
        logic               exception;
        logic               int_pending;
        logic [CAUSE_W-1:0] exc_code;
        logic [CAUSE_W-1:0] int_code;
        logic               tval_addr;   // mtval takes val
    } trap_req_t;

    typedef struct packed {
        logic                  we;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } csr_wr_t;

    typedef struct packed {
        logic            exception;
        logic            int_pending;
        logic            treturn;
        logic [XLEN-1:0] exc_trap;
        logic [XLEN-1:0] int_trap;
        logic [XLEN-1:0] mepc;
    } trap_out_t;

    // register view handed from the register file to the read path
    typedef struct packed {
        logic            mstatus_mpie;
        logic            mstatus_mie;
        logic [XLEN-1:0] mie;
        logic [XLEN-1:0] mip;
        logic [XLEN-1:0] mtvec;
        logic [XLEN-1:0] mscratch;
        logic [XLEN-1:0] mepc;
        logic [XLEN-1:0] mcause;
        logic [XLEN-1:0] mtval;
        logic [XLEN-1:0] mcycle;
        logic [XLEN-1:0] mcycleh;
        logic [XLEN-1:0] minstret;
        logic [XLEN-1:0] minstreth;
    } csr_state_t;

endpackage

`default_nettype wire

/* rtl/csr_regfile.sv */
// machine CSR register file
// trap entry, mret, counters, CSR writes and the trap-handler addresses
`timescale 1ns/100ps
`default_nettype none

module csr_regfile (
    input  logic                  s_clk_i,
    input  logic                  reset_i,
    input  csr_pkg::stage_instr_t s_instr_i,
    input  logic                  s_stall_i,
    input  logic                  s_flush_i,
    input  logic                  s_interrupted_i,   // core approved an interrupt
    input  csr_pkg::irq_lines_t   s_irq_i,
    input  csr_pkg::trap_req_t    s_trap_i,
    input  csr_pkg::csr_wr_t      s_wr_i,
    output csr_pkg::csr_state_t   s_state_o,
    output csr_pkg::trap_out_t    s_trap_o
);
    import csr_pkg::*;

    csr_state_t      r_csr;
    logic            commit;
    logic            trap_entry;
    logic            treturn;
    logic            mret_go;
    logic            instr_ret;
    logic [63:0]     cycle_inc;
    logic [63:0]     instret_inc;
    logic [XLEN-1:0] exc_trap;
    logic [XLEN-1:0] int_vec;

    assign commit     = s_instr_i.valid & ~s_flush_i & ~s_stall_i;
    assign trap_entry = commit & (s_trap_i.exception | s_interrupted_i);
    assign treturn    = s_instr_i.valid & ~s_flush_i & (s_instr_i.op == OP_MRET) &
                        ~s_trap_i.exception;
    assign mret_go    = treturn & ~s_stall_i;
    assign instr_ret  = commit & ~s_trap_i.exception & (s_instr_i.op != OP_NONE);

    assign cycle_inc   = {r_csr.mcycleh, r_csr.mcycle} + 64'd1;
    assign instret_inc = {r_csr.minstreth, r_csr.minstret} + 64'd1;

    always_ff @(posedge s_clk_i) begin
        if (reset_i) begin
            r_csr <= '0;
        end else begin
            r_csr.mip <= {20'b0, s_irq_i.meip, 3'b0, s_irq_i.mtip, 3'b0, s_irq_i.msip, 3'b0};
            {r_csr.mcycleh, r_csr.mcycle} <= cycle_inc;
            if (instr_ret) begin
                {r_csr.minstreth, r_csr.minstret} <= instret_inc;
            end

            if (trap_entry) begin
                r_csr.mepc         <= s_instr_i.pc;
                r_csr.mstatus_mpie <= r_csr.mstatus_mie;
                r_csr.mstatus_mie  <= 1'b0;
                if (s_interrupted_i) begin
                    r_csr.mcause <= {1'b1, {(XLEN-CAUSE_W-1){1'b0}}, s_trap_i.int_code};
                end else begin
                    r_csr.mcause <= {{(XLEN-CAUSE_W){1'b0}}, s_trap_i.exc_code};
                    r_csr.mtval  <= s_trap_i.tval_addr ? s_instr_i.val : '0;
                end
            end else if (mret_go) begin
                r_csr.mstatus_mie  <= r_csr.mstatus_mpie;
                r_csr.mstatus_mpie <= 1'b1;
            end else if (s_wr_i.we) begin
                // counter writes land after the increments above and win
                case (s_wr_i.addr)
                    MSTATUS: begin
                        r_csr.mstatus_mie  <= s_wr_i.data[3];
                        r_csr.mstatus_mpie <= s_wr_i.data[7];
                    end
                    MIE:       r_csr.mie       <= s_wr_i.data & MIE_MASK;
                    MTVEC:     r_csr.mtvec     <= {s_wr_i.data[XLEN-1:2], 1'b0, s_wr_i.data[0]};
                    MSCRATCH:  r_csr.mscratch  <= s_wr_i.data;
                    MEPC:      r_csr.mepc      <= s_wr_i.data;
                    MCAUSE:    r_csr.mcause    <= s_wr_i.data;
                    MTVAL:     r_csr.mtval     <= s_wr_i.data;
                    MCYCLE:    r_csr.mcycle    <= s_wr_i.data;
                    MCYCLEH:   r_csr.mcycleh   <= s_wr_i.data;
                    MINSTRET:  r_csr.minstret  <= s_wr_i.data;
                    MINSTRETH: r_csr.minstreth <= s_wr_i.data;
                    default: ;                   // read-only or unknown
                endcase
            end
        end
    end

    // handler addresses, vectored mode offsets interrupts by 4*cause
    assign exc_trap = {r_csr.mtvec[XLEN-1:2], 2'b00};
    assign int_vec  = exc_trap + {{(XLEN-CAUSE_W-2){1'b0}}, s_trap_i.int_code, 2'b00};

    assign s_state_o = r_csr;

    assign s_trap_o.exception   = s_trap_i.exception;
    assign s_trap_o.int_pending = s_trap_i.int_pending;
    assign s_trap_o.treturn     = treturn;
    assign s_trap_o.exc_trap    = exc_trap;
    assign s_trap_o.int_trap    = r_csr.mtvec[0] ? int_vec : exc_trap;
    assign s_trap_o.mepc        = r_csr.mepc;

endmodule

`default_nettype wire

/* rtl/csr_trap_eval.sv */
// trap evaluation
// flags and prioritises synchronous exceptions, evaluates pending interrupts
`timescale 1ns/100ps
`default_nettype none

module csr_trap_eval (
    input  csr_pkg::stage_instr_t      s_instr_i,
    input  logic                       s_mstatus_mie_i,
    input  logic [csr_pkg::XLEN-1:0]   s_mie_i,
    input  logic [csr_pkg::XLEN-1:0]   s_mip_i,
    output csr_pkg::trap_req_t         s_trap_o
);
    import csr_pkg::*;

    logic            is_word;
    logic            is_half;
    logic            is_store;
    logic            misaligned;
    logic            exc_iaccess;
    logic            exc_illegal;
    logic            exc_ecall;
    logic            exc_ebreak;
    logic            exc_misalign;
    logic [XLEN-1:0] pend;

    assign is_word  = (s_instr_i.op == OP_LOAD_W) | (s_instr_i.op == OP_STORE_W);
    assign is_half  = (s_instr_i.op == OP_LOAD_H) | (s_instr_i.op == OP_STORE_H);
    assign is_store = (s_instr_i.op == OP_STORE_W) | (s_instr_i.op == OP_STORE_H) |
                      (s_instr_i.op == OP_STORE_B);

    // byte accesses never misalign
    assign misaligned = (is_word & (|s_instr_i.val[1:0])) | (is_half & s_instr_i.val[0]);

    assign exc_iaccess  = s_instr_i.valid & (s_instr_i.misc == MIS_FETCH_ERR);
    assign exc_illegal  = s_instr_i.valid & (s_instr_i.misc == MIS_ILLEGAL);
    assign exc_ecall    = s_instr_i.valid & (s_instr_i.op == OP_ECALL);
    assign exc_ebreak   = s_instr_i.valid & (s_instr_i.op == OP_EBREAK);
    assign exc_misalign = s_instr_i.valid & misaligned;

    assign s_trap_o.exception = exc_iaccess | exc_illegal | exc_ecall | exc_ebreak |
                                exc_misalign;

    always_comb begin : exc_priority
        s_trap_o.exc_code  = '0;
        s_trap_o.tval_addr = 1'b0;
        if (exc_iaccess) begin
            s_trap_o.exc_code = EXC_IACCESS;
        end else if (exc_illegal) begin
            s_trap_o.exc_code = EXC_ILLEGAL;
        end else if (exc_ecall) begin
            s_trap_o.exc_code = EXC_ECALL_M;
        end else if (exc_ebreak) begin
            s_trap_o.exc_code = EXC_EBREAK;
        end else if (exc_misalign) begin
            s_trap_o.exc_code  = is_store ? EXC_SMISALIGN : EXC_LMISALIGN;
            s_trap_o.tval_addr = 1'b1;       // faulting address goes to mtval
        end
    end

    assign pend = s_mie_i & s_mip_i;

    assign s_trap_o.int_pending = (|pend) & s_mstatus_mie_i;

    always_comb begin : int_priority
        if (pend[11]) begin
            s_trap_o.int_code = INT_MEI;
        end else if (pend[3]) begin
            s_trap_o.int_code = INT_MSI;
        end else if (pend[7]) begin
            s_trap_o.int_code = INT_MTI;
        end else begin
            s_trap_o.int_code = '0;          // nothing pending
        end
    end

endmodule

`default_nettype wire

/* rtl/csr_unit.sv */
// machine-mode CSR unit top
// joins trap evaluation, CSR access and the register file beside the MA stage
`timescale 1ns/100ps
`default_nettype none

module csr_unit (
    input  logic                       s_clk_i,
    input  logic                       reset_i,
    input  csr_pkg::stage_instr_t      s_instr_i,
    input  logic                       s_stall_i,
    input  logic                       s_flush_i,
    input  logic                       s_interrupted_i,
    input  csr_pkg::irq_lines_t        s_irq_i,
    output logic [csr_pkg::XLEN-1:0]   s_csr_r_o,      // value before this write
    output csr_pkg::trap_out_t         s_trap_o
);
    import csr_pkg::*;

    trap_req_t  trap_req;
    csr_wr_t    csr_wr;
    csr_state_t csr_state;

    csr_trap_eval i_csr_trap_eval (
        .s_instr_i       (s_instr_i),
        .s_mstatus_mie_i (csr_state.mstatus_mie),
        .s_mie_i         (csr_state.mie),
        .s_mip_i         (csr_state.mip),
        .s_trap_o        (trap_req)
    );

    csr_access i_csr_access (
        .s_instr_i (s_instr_i),
        .s_flush_i (s_flush_i),
        .s_stall_i (s_stall_i),
        .s_state_i (csr_state),
        .s_rdata_o (s_csr_r_o),
        .s_wr_o    (csr_wr)
    );

    csr_regfile i_csr_regfile (
        .s_clk_i         (s_clk_i),
        .reset_i         (reset_i),
        .s_instr_i       (s_instr_i),
        .s_stall_i       (s_stall_i),
        .s_flush_i       (s_flush_i),
        .s_interrupted_i (s_interrupted_i),
        .s_irq_i         (s_irq_i),
        .s_trap_i        (trap_req),
        .s_wr_i          (csr_wr),
        .s_state_o       (csr_state),
        .s_trap_o        (s_trap_o)
    );

endmodule

`default_nettype wire

/* sim/csr_unit_props.sv */
// concurrent checks on the CSR unit trap outputs
// bound into every csr_unit instance
`timescale 1ns/100ps
`default_nettype none

module csr_unit_props (
    input logic                  clk_i,
    input logic                  reset_i,
    input csr_pkg::stage_instr_t instr_i,
    input logic                  stall_i,
    input logic                  flush_i,
    input logic                  interrupted_i,
    input csr_pkg::trap_out_t    trap_i
);

    // handler base is always word aligned
    exc_trap_aligned: assert property (@(posedge clk_i) disable iff (reset_i)
        trap_i.exc_trap[1:0] == 2'b00)
        else $error("exc_trap has low address bits set");

    no_treturn_in_reset: assert property (@(posedge clk_i)
        reset_i |-> !trap_i.treturn)
        else $error("treturn high while reset is active");

    idle_after_reset: assert property (@(posedge clk_i)
        $fell(reset_i) |-> !trap_i.exception && !trap_i.int_pending && !trap_i.treturn &&
                           trap_i.exc_trap == '0 && trap_i.int_trap == '0)
        else $error("trap outputs active right after reset");

    // MIE is cleared by the entry, so nothing stays pending
    int_entry_clears: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_i.valid && interrupted_i && !stall_i && !flush_i |=> !trap_i.int_pending)
        else $error("int_pending still high after interrupt entry");

endmodule

bind csr_unit csr_unit_props i_csr_unit_props (
    .clk_i         (s_clk_i),
    .reset_i       (reset_i),
    .instr_i       (s_instr_i),
    .stall_i       (s_stall_i),
    .flush_i       (s_flush_i),
    .interrupted_i (s_interrupted_i),
    .trap_i        (s_trap_o)
);

`default_nettype wire

/* sim/csr_unit_tb.sv */
// testbench for the machine-mode CSR unit
// random CSR accesses, traps, interrupts and counters against a shadow model
`timescale 1ns/100ps
`default_nettype none

module csr_unit_tb;
    import csr_pkg::*;

    localparam int unsigned     TIMEOUT_CYCLES = 2000;   // tests take about 600
    localparam logic [11:0]     UNKNOWN_CSR    = 12'h7C0;

    logic         clk = 1'b0;
    logic         reset;
    stage_instr_t instr;
    logic         stall;
    logic         flush;
    logic         interrupted;
    irq_lines_t   irq;
    logic [31:0]  csr_r;
    trap_out_t    trap;

    logic [31:0]  cap_rdata;                 // outputs captured mid-cycle
    trap_out_t    cap_trap;
    logic [11:0]  addr_tab [4];
    logic [31:0]  shadow   [4];              // mscratch, mepc, mtval, mtvec
    int unsigned  cycle_cnt = 0;

    csr_unit i_csr_unit (
        .s_clk_i         (clk),
        .reset_i         (reset),
        .s_instr_i       (instr),
        .s_stall_i       (stall),
        .s_flush_i       (flush),
        .s_interrupted_i (interrupted),
        .s_irq_i         (irq),
        .s_csr_r_o       (csr_r),
        .s_trap_o        (trap)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            stop_on_error("timeout, the test sequence did not finish");
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            stop_on_error($sformatf("FAILED %s: expected 0x%08h actual 0x%08h", name, exp, act));
        end
    endtask

    // replace, set or clear on the old value
    function automatic logic [31:0] csr_result(input instr_op_e op, input logic [31:0] old,
                                               input logic [31:0] opnd);
        case (op)
            OP_CSRRS: return old | opnd;
            OP_CSRRC: return old & ~opnd;
            default:  return opnd;
        endcase
    endfunction

    task automatic set_idle();
        instr       = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        interrupted = 1'b0;
    endtask

    // one stage cycle, entered and left 2 ns after the rising edge
    task automatic issue(input logic vld, input instr_op_e op, input logic [11:0] addr,
                         input logic [31:0] val, input logic [31:0] pc,
                         input logic stl, input logic fls, input logic intr);
        instr.valid    = vld;
        instr.op       = op;
        instr.misc     = MIS_NONE;
        instr.csr_addr = addr;
        instr.val      = val;
        instr.pc       = pc;
        stall          = stl;
        flush          = fls;
        interrupted    = intr;
        #10;
        cap_rdata = csr_r;
        cap_trap  = trap;
        @(posedge clk);
        #2;
        set_idle();
    endtask

    task automatic csr_cmd(input instr_op_e op, input logic [11:0] addr, input logic [31:0] val);
        issue(1'b1, op, addr, val, 32'h0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic peek(input logic [11:0] addr);
        issue(1'b0, OP_NONE, addr, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0);   // read only, no commit
    endtask

    task automatic wait_int_pending();
        int unsigned polls = 0;
        peek(MIP);
        while (!cap_trap.int_pending) begin
            polls++;
            if (polls == 8) begin
                stop_on_error("int_pending did not rise after the interrupt line was raised");
            end
            peek(MIP);
        end
    endtask

    initial begin : stimulus
        logic [1:0]  idx;
        logic [1:0]  sel;
        instr_op_e   op;
        logic [31:0] val;
        logic [31:0] pc;
        logic [31:0] base;
        logic [31:0] cyc;
        logic        vld;
        logic        stl;
        logic        fls;
        logic        exc;
        int unsigned count;

        void'($urandom(32'h33b0_c255));
        reset = 1'b1;
        irq   = '0;
        set_idle();
        addr_tab = '{MSCRATCH, MEPC, MTVAL, MTVEC};
        shadow   = '{default: 32'h0};
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (2) @(posedge clk);
        #2;

        // random CSR operations, each returns the previous value
        repeat (200) begin
            idx = 2'($urandom_range(3));
            sel = 2'($urandom_range(2));
            val = $urandom;
            case (sel)
                2'd0:    op = OP_CSRRW;
                2'd1:    op = OP_CSRRS;
                default: op = OP_CSRRC;
            endcase
            csr_cmd(op, addr_tab[idx], val);
            check("s_csr_r_o old value", shadow[idx], cap_rdata);
            shadow[idx] = csr_result(op, shadow[idx], val);
            if (addr_tab[idx] == MTVEC) begin
                shadow[idx][1] = 1'b0;       // mtvec bit 1 reads zero
            end
        end
        idx = 2'd0;
        repeat (4) begin
            peek(addr_tab[idx]);
            check("s_csr_r_o readback", shadow[idx], cap_rdata);
            idx++;
        end
        peek(UNKNOWN_CSR);
        check("s_csr_r_o unknown csr", 32'h0, cap_rdata);
        peek(MISA);
        check("s_csr_r_o misa", MISA_VAL, cap_rdata);

        // ecall then mret
        csr_cmd(OP_CSRRS, MSTATUS, 32'h8);
        repeat (4) begin
            pc = $urandom & 32'hFFFF_FFFC;
            issue(1'b1, OP_ECALL, 12'h0, 32'h0, pc, 1'b0, 1'b0, 1'b0);
            check("exception", 32'h1, 32'(cap_trap.exception));
            check("exc_trap", shadow[3] & 32'hFFFF_FFFC, cap_trap.exc_trap);
            peek(MEPC);
            check("mepc", pc, cap_rdata);
            peek(MCAUSE);
            check("mcause", 32'd11, cap_rdata);
            peek(MSTATUS);
            check("mstatus after ecall", MSTATUS_MPP_BITS | 32'h80, cap_rdata);
            issue(1'b1, OP_MRET, 12'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0);
            check("treturn", 32'h1, 32'(cap_trap.treturn));
            check("s_mepc_o", pc, cap_trap.mepc);
            peek(MSTATUS);
            check("mstatus after mret", MSTATUS_MPP_BITS | 32'h88, cap_rdata);
        end

        // misaligned accesses and ebreak
        val = $urandom | 32'h1;
        issue(1'b1, OP_LOAD_H, 12'h0, val, 32'h100, 1'b0, 1'b0, 1'b0);
        check("exception", 32'h1, 32'(cap_trap.exception));
        peek(MCAUSE);
        check("mcause", 32'd4, cap_rdata);
        peek(MTVAL);
        check("mtval", val, cap_rdata);
        val = ($urandom & 32'hFFFF_FFFC) | 32'h2;
        issue(1'b1, OP_STORE_W, 12'h0, val, 32'h104, 1'b0, 1'b0, 1'b0);
        check("exception", 32'h1, 32'(cap_trap.exception));
        peek(MCAUSE);
        check("mcause", 32'd6, cap_rdata);
        peek(MTVAL);
        check("mtval", val, cap_rdata);
        issue(1'b1, OP_LOAD_W, 12'h0, val & 32'hFFFF_FFFC, 32'h108, 1'b0, 1'b0, 1'b0);
        check("exception", 32'h0, 32'(cap_trap.exception));
        issue(1'b1, OP_EBREAK, 12'h0, $urandom, 32'h10C, 1'b0, 1'b0, 1'b0);
        peek(MCAUSE);
        check("mcause", 32'd3, cap_rdata);
        peek(MTVAL);
        check("mtval", 32'h0, cap_rdata);
        shadow[2] = $urandom & 32'hFFFF_FFFE;
        csr_cmd(OP_CSRRW, MTVAL, shadow[2]);

        // timer then external interrupt, vectored mode
        base = $urandom & 32'hFFFF_FFFC;
        csr_cmd(OP_CSRRW, MTVEC, base | 32'h1);
        csr_cmd(OP_CSRRW, MIE, 32'h80);
        csr_cmd(OP_CSRRS, MSTATUS, 32'h8);
        irq.mtip = 1'b1;
        wait_int_pending();
        check("int_trap", base + 32'd28, cap_trap.int_trap);
        pc = $urandom & 32'hFFFF_FFFC;
        // the interrupt wins over a misaligned load
        issue(1'b1, OP_LOAD_H, 12'h0, ~shadow[2], pc, 1'b0, 1'b0, 1'b1);
        check("int_pending", 32'h1, 32'(cap_trap.int_pending));
        peek(MCAUSE);
        check("mcause", 32'h8000_0007, cap_rdata);
        check("int_pending", 32'h0, 32'(cap_trap.int_pending));
        peek(MEPC);
        check("mepc", pc, cap_rdata);
        peek(MTVAL);
        check("mtval", shadow[2], cap_rdata);    // untouched by interrupts
        csr_cmd(OP_CSRRS, MIE, 32'h800);
        irq.meip = 1'b1;
        csr_cmd(OP_CSRRS, MSTATUS, 32'h8);
        wait_int_pending();
        check("int_trap", base + 32'd44, cap_trap.int_trap);
        issue(1'b1, OP_OTHER, 12'h0, 32'h0, pc, 1'b0, 1'b0, 1'b1);
        peek(MCAUSE);
        check("mcause", 32'h8000_000B, cap_rdata);
        irq = '0;
        csr_cmd(OP_CSRRW, MIE, 32'h0);

        // stalled or flushed writes leave mscratch alone
        val = $urandom;
        issue(1'b1, OP_CSRRW, MSCRATCH, val, 32'h0, 1'b1, 1'b0, 1'b0);
        check("s_csr_r_o under stall", shadow[0], cap_rdata);
        issue(1'b1, OP_CSRRW, MSCRATCH, val, 32'h0, 1'b0, 1'b1, 1'b0);
        peek(MSCRATCH);
        check("mscratch", shadow[0], cap_rdata);
        peek(MCYCLE);
        cyc = cap_rdata;
        peek(MCYCLE);
        check("mcycle", cyc + 32'd1, cap_rdata);

        // minstret counts committed, non-trapping instructions only
        csr_cmd(OP_CSRRW, MINSTRET, 32'h0);
        count = 0;
        repeat (200) begin
            vld = 1'($urandom);
            stl = ($urandom_range(3) == 0);
            fls = ($urandom_range(3) == 0);
            val = $urandom;
            sel = 2'($urandom_range(3));
            exc = 1'b0;
            case (sel)
                2'd0: op = OP_NONE;
                2'd1: op = OP_OTHER;
                2'd2: op = OP_LOAD_B;
                default: begin
                    op  = OP_LOAD_W;
                    exc = (val[1:0] != 2'b00);
                end
            endcase
            issue(vld, op, 12'h0, val, 32'h200, stl, fls, 1'b0);
            if (vld && !stl && !fls && !exc && op != OP_NONE) begin
                count++;
            end
        end
        peek(MINSTRET);
        check("minstret", count, cap_rdata);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
